// ==== design/soc_mem_pkg.sv ====
package soc_mem_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// the region code is the top twelve address bits
	localparam int REGION_W = 12;
	localparam int REGION_LSB = ADDR_W - REGION_W;

	// firmware RAM geometry
	localparam int FW_WORDS = 512;
	localparam int FW_INDEX_W = $clog2(FW_WORDS);
	localparam int FW_INDEX_LSB = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [REGION_W-1:0] region_t;
	typedef logic [FW_INDEX_W-1:0] fw_index_t;

	// address map
	localparam region_t REGION_FW = 12'h000;
	localparam region_t REGION_REG = 12'h800;

	// preload image for the firmware RAM
	localparam string FW_IMAGE = "design/firmware.hex";

	// request from the host, a nonzero strobe marks a write
	typedef struct packed {
		logic valid;
		logic instr;
		addr_t addr;
		word_t wdata;
		strb_t wstrb;
	} mem_req_t;

	// response back to the host
	typedef struct packed {
		logic ready;
		word_t rdata;
	} mem_rsp_t;

	// RAM write step
	typedef enum logic [0:0] {
		FW_IDLE,
		FW_MERGE
	} fw_state_t;

	function automatic region_t region_of(addr_t addr);
		return addr[REGION_LSB +: REGION_W];
	endfunction

	// word index inside the RAM, upper bits alias every 2 KB
	function automatic fw_index_t fw_index_of(addr_t addr);
		return addr[FW_INDEX_LSB +: FW_INDEX_W];
	endfunction

	function automatic logic is_write(mem_req_t req);
		return req.wstrb != '0;
	endfunction

	// take each byte from new_data where its strobe is set, else keep old_word
	function automatic word_t merge_bytes(word_t new_data, strb_t strb, word_t old_word);
		word_t merged;
		for (int i = 0; i < STRB_W; i++)
		begin
			merged[8*i +: 8] = strb[i] ? new_data[8*i +: 8] : old_word[8*i +: 8];
		end
		return merged;
	endfunction

endpackage

// ==== design/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder
(
	input soc_mem_pkg::mem_req_t i_req,
	output soc_mem_pkg::mem_req_t o_fw_req,
	output soc_mem_pkg::mem_req_t o_reg_req,
	input soc_mem_pkg::mem_rsp_t i_fw_rsp,
	input soc_mem_pkg::mem_rsp_t i_reg_rsp,
	output soc_mem_pkg::mem_rsp_t o_rsp
);
	import soc_mem_pkg::*;

	region_t region;
	logic sel_fw;
	logic sel_reg;

	// region match, at most one of these is set
	assign region = region_of(i_req.addr);
	assign sel_fw = region == REGION_FW;
	assign sel_reg = region == REGION_REG;

	// request fan out
	always_comb
	begin
		o_fw_req = i_req;
		o_fw_req.valid = i_req.valid && sel_fw;

		o_reg_req = i_req;
		o_reg_req.valid = i_req.valid && sel_reg;
	end

	// response select
	// an unmapped address never sees ready, the host has to give up on its own
	always_comb
	begin
		o_rsp = '0;
		if (sel_fw)
		begin
			o_rsp = i_fw_rsp;
		end
		else if (sel_reg)
		begin
			o_rsp = i_reg_rsp;
		end
	end

endmodule

// ==== design/fw_ram.sv ====
`timescale 1ns/1ps

module fw_ram
(
	input logic clk,
	input logic resetn,
	input soc_mem_pkg::mem_req_t i_req,
	output soc_mem_pkg::mem_rsp_t o_rsp
);
	import soc_mem_pkg::*;

	word_t mem [FW_WORDS];

	fw_index_t index;
	fw_state_t state;

	logic start;
	logic write;
	logic mem_we;
	logic ready_q;

	// old word on a write, read data on a read
	word_t word_q;
	word_t merged;

	initial
	begin
		$readmemh(FW_IMAGE, mem);
	end

	assign index = fw_index_of(i_req.addr);
	assign write = is_write(i_req);

	// a new access starts only in idle and not while ready is still up,
	// so a held request is answered once and then restarts
	assign start = i_req.valid && !ready_q && state == FW_IDLE;

	// merge step writes back during the second valid cycle
	assign mem_we = !resetn && state == FW_MERGE && i_req.valid;
	assign merged = merge_bytes(i_req.wdata, i_req.wstrb, word_q);

	// control
	always_ff @(posedge clk)
	begin
		if (resetn)
		begin
			state <= FW_IDLE;
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= 1'b0;
			case (state)
				FW_IDLE:
				begin
					if (start)
					begin
						// reads answer next cycle, writes go through the merge step
						if (write)
							state <= FW_MERGE;
						else
							ready_q <= 1'b1;
					end
				end
				FW_MERGE:
				begin
					state <= FW_IDLE;
					ready_q <= i_req.valid;
				end
			endcase
		end
	end

	// memory array and word register
	always_ff @(posedge clk)
	begin
		if (mem_we)
			mem[index] <= merged;

		if (start)
			word_q <= mem[index];
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = word_q;

endmodule

// ==== design/test_reg.sv ====
`timescale 1ns/1ps

module test_reg
(
	input logic clk,
	input logic resetn,
	input soc_mem_pkg::mem_req_t i_req,
	output soc_mem_pkg::mem_rsp_t o_rsp
);
	import soc_mem_pkg::*;

	word_t value_q;
	logic we;

	// instruction fetches only ever read this register
	assign we = i_req.valid && !i_req.instr && is_write(i_req);

	always_ff @(posedge clk)
	begin
		if (resetn)
		begin
			value_q <= '0;
		end
		else if (we)
		begin
			value_q <= merge_bytes(i_req.wdata, i_req.wstrb, value_q);
		end
	end

	// answered in the same cycle, the write lands on the closing edge
	assign o_rsp.ready = i_req.valid;
	assign o_rsp.rdata = value_q;

endmodule

// ==== design/soc_mem_top.sv ====
`timescale 1ns/1ps

module soc_mem_top
(
	input logic clk,
	input logic resetn,
	input soc_mem_pkg::mem_req_t i_req,
	output soc_mem_pkg::mem_rsp_t o_rsp
);
	import soc_mem_pkg::*;

	// per target request and response
	mem_req_t fw_req;
	mem_req_t reg_req;
	mem_rsp_t fw_rsp;
	mem_rsp_t reg_rsp;

	// address decode, no register stage
	bus_decoder u_decoder
	(
		.i_req(i_req),
		.o_fw_req(fw_req),
		.o_reg_req(reg_req),
		.i_fw_rsp(fw_rsp),
		.i_reg_rsp(reg_rsp),
		.o_rsp(o_rsp)
	);

	// 0x000xxxxx
	fw_ram u_fw_ram
	(
		.clk(clk),
		.resetn(resetn),
		.i_req(fw_req),
		.o_rsp(fw_rsp)
	);

	// 0x800xxxxx
	test_reg u_test_reg
	(
		.clk(clk),
		.resetn(resetn),
		.i_req(reg_req),
		.o_rsp(reg_rsp)
	);

endmodule

// ==== bench/soc_mem_chk.sv ====
`timescale 1ns/1ps

module soc_mem_chk
(
	input logic clk,
	input logic resetn,
	input soc_mem_pkg::mem_req_t i_req,
	input soc_mem_pkg::mem_rsp_t i_rsp
);

	// ready only ever answers a live request
	ready_needs_valid: assert property (
		@(posedge clk) disable iff (resetn)
		i_rsp.ready |-> i_req.valid
	)
	else
		$error("ready is high while valid is low");

	// first cycle out of reset
	ready_low_after_reset: assert property (
		@(posedge clk)
		$fell(resetn) |-> !i_rsp.ready
	)
	else
		$error("ready is high in the first cycle after reset");

	// a held answer keeps its data
	rdata_stable_when_held: assert property (
		@(posedge clk) disable iff (resetn)
		(i_rsp.ready && i_req.valid && $past(i_rsp.ready && i_req.valid))
			|-> $stable(i_rsp.rdata)
	)
	else
		$error("rdata changed while ready was held with valid");

endmodule

bind soc_mem_top soc_mem_chk u_soc_mem_chk
(
	.clk(clk),
	.resetn(resetn),
	.i_req(i_req),
	.i_rsp(o_rsp)
);

// ==== bench/tb_soc_mem.sv ====
`timescale 1ns/1ps

module tb_soc_mem;
	import soc_mem_pkg::*;

	localparam int DRIVE_DELAY = 2;
	// longest legal access is three cycles plus one idle cycle
	localparam int ACCESS_LIMIT = 16;
	// about 75 accesses of at most 4 cycles need roughly 320 cycles
	localparam int TIMEOUT_CYCLES = 2000;
	localparam addr_t REG_ADDR = 32'h8000_0000;
	localparam addr_t UNMAPPED_ADDR = 32'h4000_0000;

	logic clk;
	logic resetn;
	mem_req_t req;
	mem_rsp_t rsp;

	int errors;
	int checks;
	int cycles;
	logic [31:0] lcg_state;

	// last RAM word written and its value
	addr_t last_fw_addr;
	word_t last_fw_value;

	soc_mem_top u_soc_mem_top
	(
		.clk(clk),
		.resetn(resetn),
		.i_req(req),
		.o_rsp(rsp)
	);

	always #20 clk = ~clk;

	// run limit
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("checks: %0d, errors: %0d", checks, errors + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected word after a strobed write
	function automatic logic [31:0] apply_strobe(logic [31:0] new_data, logic [3:0] strb,
		logic [31:0] old_word);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (new_data & mask) | (old_word & ~mask);
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("FAILED %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	// host access starting and ending just after a rising edge
	task automatic bus_transfer(input addr_t addr, input word_t wdata, input strb_t strb,
		input logic instr, input int limit, output word_t rdata, output logic answered);
		int waited;
		waited = 0;
		answered = 1'b0;
		rdata = '0;
		req.valid = 1'b1;
		req.instr = instr;
		req.addr = addr;
		req.wdata = wdata;
		req.wstrb = strb;
		while (!answered && waited < limit)
		begin
			@(negedge clk);
			if (rsp.ready)
			begin
				answered = 1'b1;
				rdata = rsp.rdata;
			end
			@(posedge clk);
			#(DRIVE_DELAY);
			waited++;
		end
		req = '0;
		// valid stays low for a cycle between requests
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic bus_read(input addr_t addr, output word_t data);
		logic answered;
		bus_transfer(addr, '0, '0, 1'b0, ACCESS_LIMIT, data, answered);
		if (!answered)
		begin
			errors++;
			$display("read at %08h was never answered with ready", addr);
		end
	endtask

	task automatic bus_write(input addr_t addr, input word_t data, input strb_t strb,
		input logic instr);
		word_t unused;
		logic answered;
		bus_transfer(addr, data, strb, instr, ACCESS_LIMIT, unused, answered);
		if (!answered)
		begin
			errors++;
			$display("write at %08h was never answered with ready", addr);
		end
	endtask

	task automatic test_reset();
		word_t data;
		@(negedge clk);
		check("reset_ready", 32'd0, {31'd0, rsp.ready});
		@(posedge clk);
		#(DRIVE_DELAY);
		bus_read(REG_ADDR, data);
		check("reset_test_reg", 32'd0, data);
	endtask

	task automatic test_preload();
		word_t data;
		bus_read(32'h0000_0000, data);
		check("preload_word0", 32'h1740_006F, data);
		bus_read(32'h0000_0004, data);
		check("preload_word1", 32'h0000_0013, data);
	endtask

	task automatic test_ram_full();
		logic [31:0] rnd;
		fw_index_t idx;
		addr_t addr;
		word_t data;
		word_t rd;
		for (int i = 0; i < 6; i++)
		begin
			rnd = next_random();
			idx = rnd[8:0];
			addr = {21'd0, idx, 2'b00};
			data = next_random();
			bus_write(addr, data, 4'hf, 1'b0);
			bus_read(addr, rd);
			check($sformatf("ram_full_%0d", i), data, rd);
			// bit 11 lies above the index and aliases to the same word
			bus_read(addr + 32'h800, rd);
			check($sformatf("ram_alias_%0d", i), data, rd);
			last_fw_addr = addr;
			last_fw_value = data;
		end
	endtask

	task automatic test_ram_partial();
		logic [31:0] rnd;
		addr_t addr;
		word_t prev;
		word_t data;
		word_t expected;
		word_t rd;
		strb_t strb;
		rnd = next_random();
		addr = {21'd0, rnd[8:0], 2'b00};
		prev = next_random();
		bus_write(addr, prev, 4'hf, 1'b0);
		for (int s = 1; s < 16; s++)
		begin
			strb = 4'(s);
			data = next_random();
			expected = apply_strobe(data, strb, prev);
			bus_write(addr, data, strb, 1'b0);
			bus_read(addr, rd);
			check($sformatf("ram_strobe_%h", strb), expected, rd);
			prev = expected;
		end
		last_fw_addr = addr;
		last_fw_value = prev;
	endtask

	task automatic test_test_reg();
		logic [31:0] rnd;
		word_t prev;
		word_t data;
		word_t rd;
		strb_t strb;
		// nothing has written the register since reset
		prev = '0;
		for (int i = 0; i < 6; i++)
		begin
			rnd = next_random();
			strb = (rnd[3:0] == 4'h0) ? 4'hf : rnd[3:0];
			data = next_random();
			bus_write(REG_ADDR + {rnd[11:4], 2'b00}, data, strb, 1'b0);
			prev = apply_strobe(data, strb, prev);
			bus_read(REG_ADDR, rd);
			check($sformatf("reg_write_%0d", i), prev, rd);
		end
		// instruction-flagged write has to be ignored
		bus_write(REG_ADDR, ~prev, 4'hf, 1'b1);
		bus_read(REG_ADDR, rd);
		check("reg_instr_write", prev, rd);
		// RAM traffic in between
		bus_write(last_fw_addr, last_fw_value, 4'hf, 1'b0);
		bus_read(last_fw_addr, rd);
		check("reg_ram_between", last_fw_value, rd);
		bus_read(REG_ADDR, rd);
		check("reg_kept", prev, rd);
		// a held read keeps being answered with the same word
		req.valid = 1'b1;
		req.addr = REG_ADDR;
		for (int c = 0; c < 3; c++)
		begin
			@(negedge clk);
			check($sformatf("reg_held_ready_%0d", c), 32'd1, {31'd0, rsp.ready});
			check($sformatf("reg_held_data_%0d", c), prev, rsp.rdata);
			@(posedge clk);
			#(DRIVE_DELAY);
		end
		req = '0;
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic test_unmapped();
		word_t rd;
		logic answered;
		bus_transfer(UNMAPPED_ADDR, '0, '0, 1'b0, 8, rd, answered);
		checks++;
		if (answered)
		begin
			errors++;
			$display("read at unmapped address %08h was answered with ready", UNMAPPED_ADDR);
		end
		bus_read(last_fw_addr, rd);
		check("ram_after_unmapped", last_fw_value, rd);
	endtask

	initial
	begin
		clk = 1'b0;
		resetn = 1'b1;
		req = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		lcg_state = 32'd68;
		last_fw_addr = '0;
		last_fw_value = '0;
		repeat (5) @(posedge clk);
		#(DRIVE_DELAY);
		resetn = 1'b0;

		test_reset();
		test_preload();
		test_ram_full();
		test_ram_partial();
		test_test_reg();
		test_unmapped();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== build.f ====
design/soc_mem_pkg.sv
design/bus_decoder.sv
design/fw_ram.sv
design/test_reg.sv
design/soc_mem_top.sv
bench/soc_mem_chk.sv
bench/tb_soc_mem.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the soc_mem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module tb_soc_mem

# the simulator status is not trusted alone, the verdict comes from the output
out=$(./obj_dir/Vtb_soc_mem 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation passed"; then
	exit 0
else
	exit 1
fi

// ==== design/firmware.hex ====
// one 32-bit instruction word per line, word 0 first
1740006F
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
00000013
